// File: sources.f
+incdir+rtl
+incdir+verification
rtl/rv_isa_pkg.sv
rtl/cpu_ctrl_pkg.sv
rtl/program_counter.sv
rtl/pipeline_control.sv
rtl/fetch_stage.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/cpu_core.sv
verification/tb_cpu_core.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_cpu_core -f sources.f

run: compile
	./obj_dir/Vtb_cpu_core | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/tb_program_table.svh
// test programs with preloaded data and expected store sequences, included inside the testbench
`ifndef TB_PROGRAM_TABLE_SVH
`define TB_PROGRAM_TABLE_SVH

task automatic add_instr(input int p, input logic [31:0] word);
    prog_code[p][prog_len[p]] = word;
    prog_len[p]++;
endtask

task automatic add_expected_store(input int p, input logic [63:0] addr,
                                  input logic [63:0] data);
    exp_addr[p][exp_count[p]] = addr;
    exp_data[p][exp_count[p]] = data;
    exp_count[p]++;
endtask

task automatic build_program_table();
    for (int p = 0; p < NUM_PROGRAMS; p++) begin
        prog_len[p]  = 0;
        exp_count[p] = 0;
        for (int i = 0; i < 4; i++) data_init[p][i] = '0;
    end
    // program 0: register-register ops on x1 = -5, x2 = 3
    add_instr(0, itype_word('h13, 0, 1, 0, -5));
    add_instr(0, itype_word('h13, 0, 2, 0, 3));
    add_instr(0, rtype_word(0, 0, 3, 1, 2));          // add
    add_instr(0, store_word(3, 0, 'h100));
    add_instr(0, rtype_word('h20, 0, 4, 2, 1));       // sub x2 - x1
    add_instr(0, store_word(4, 0, 'h108));
    add_instr(0, rtype_word(0, 1, 5, 2, 2));          // sll
    add_instr(0, store_word(5, 0, 'h110));
    add_instr(0, rtype_word(0, 2, 6, 1, 2));          // slt
    add_instr(0, store_word(6, 0, 'h118));
    add_instr(0, rtype_word(0, 3, 7, 1, 2));          // sltu
    add_instr(0, store_word(7, 0, 'h120));
    add_instr(0, rtype_word(0, 4, 8, 1, 2));          // xor
    add_instr(0, store_word(8, 0, 'h128));
    add_instr(0, rtype_word(0, 5, 9, 1, 2));          // srl
    add_instr(0, store_word(9, 0, 'h130));
    add_instr(0, rtype_word('h20, 5, 11, 1, 2));      // sra
    add_instr(0, store_word(11, 0, 'h138));
    add_instr(0, rtype_word(0, 6, 12, 1, 2));         // or
    add_instr(0, store_word(12, 0, 'h140));
    add_instr(0, rtype_word(0, 7, 13, 1, 2));         // and
    add_instr(0, store_word(13, 0, 'h148));
    add_instr(0, 32'h0010_0073);                      // ebreak
    add_expected_store(0, 'h100, 64'hFFFF_FFFF_FFFF_FFFE);
    add_expected_store(0, 'h108, 64'h8);
    add_expected_store(0, 'h110, 64'h18);
    add_expected_store(0, 'h118, 64'h1);
    add_expected_store(0, 'h120, 64'h0);
    add_expected_store(0, 'h128, 64'hFFFF_FFFF_FFFF_FFF8);
    add_expected_store(0, 'h130, 64'h1FFF_FFFF_FFFF_FFFF);
    add_expected_store(0, 'h138, 64'hFFFF_FFFF_FFFF_FFFF);
    add_expected_store(0, 'h140, 64'hFFFF_FFFF_FFFF_FFFB);
    add_expected_store(0, 'h148, 64'h3);
    // program 1: immediate forms, lui and auipc
    add_instr(1, itype_word('h13, 0, 1, 0, -5));
    add_instr(1, itype_word('h13, 2, 2, 1, -4));      // slti
    add_instr(1, store_word(2, 0, 'h100));
    add_instr(1, itype_word('h13, 3, 3, 1, 5));       // sltiu
    add_instr(1, store_word(3, 0, 'h108));
    add_instr(1, itype_word('h13, 4, 4, 1, 'hF));     // xori
    add_instr(1, store_word(4, 0, 'h110));
    add_instr(1, itype_word('h13, 6, 5, 2, 'h40));    // ori
    add_instr(1, store_word(5, 0, 'h118));
    add_instr(1, itype_word('h13, 7, 6, 1, 'h7F));    // andi
    add_instr(1, store_word(6, 0, 'h120));
    add_instr(1, itype_word('h13, 1, 7, 2, 40));      // slli
    add_instr(1, store_word(7, 0, 'h128));
    add_instr(1, itype_word('h13, 5, 8, 1, 60));      // srli
    add_instr(1, store_word(8, 0, 'h130));
    add_instr(1, itype_word('h13, 5, 9, 1, 'h401));   // srai
    add_instr(1, store_word(9, 0, 'h138));
    add_instr(1, utype_word('h37, 11, 'h80000));      // lui
    add_instr(1, store_word(11, 0, 'h140));
    add_instr(1, utype_word('h17, 12, 1));            // auipc at 0x4c
    add_instr(1, store_word(12, 0, 'h148));
    add_instr(1, 32'h0010_0073);
    add_expected_store(1, 'h100, 64'h1);
    add_expected_store(1, 'h108, 64'h0);
    add_expected_store(1, 'h110, 64'hFFFF_FFFF_FFFF_FFF4);
    add_expected_store(1, 'h118, 64'h41);
    add_expected_store(1, 'h120, 64'h7B);
    add_expected_store(1, 'h128, 64'h0000_0100_0000_0000);
    add_expected_store(1, 'h130, 64'hF);
    add_expected_store(1, 'h138, 64'hFFFF_FFFF_FFFF_FFFD);
    add_expected_store(1, 'h140, 64'hFFFF_FFFF_8000_0000);
    add_expected_store(1, 'h148, 64'h104C);
    // program 2: ld / sd, x0 stays zero, no store after ebreak
    data_init[2][0] = 64'h0123_4567_89AB_CDEF;
    data_init[2][1] = 64'hFEDC_BA98_7654_3210;
    add_instr(2, itype_word('h03, 3, 1, 0, 'h80));    // ld
    add_instr(2, store_word(1, 0, 'h100));
    add_instr(2, itype_word('h13, 0, 2, 0, 8));
    add_instr(2, itype_word('h03, 3, 3, 2, 'h80));
    add_instr(2, store_word(3, 0, 'h108));
    add_instr(2, itype_word('h13, 0, 0, 0, 55));      // write to x0
    add_instr(2, store_word(0, 0, 'h110));
    add_instr(2, 32'h0010_0073);
    add_instr(2, store_word(1, 0, 'h118));            // must never appear
    add_expected_store(2, 'h100, 64'h0123_4567_89AB_CDEF);
    add_expected_store(2, 'h108, 64'hFEDC_BA98_7654_3210);
    add_expected_store(2, 'h110, 64'h0);
    // program 3: each branch taken then not taken, x1 = -1, x2 = 1
    add_instr(3, itype_word('h13, 0, 1, 0, -1));
    add_instr(3, itype_word('h13, 0, 2, 0, 1));
    add_instr(3, branch_word(0, 1, 1, 8));            // beq taken
    add_instr(3, store_word(1, 0, 'h1F8));
    add_instr(3, branch_word(0, 1, 2, 8));
    add_instr(3, store_word(2, 0, 'h100));
    add_instr(3, branch_word(1, 1, 2, 8));            // bne taken
    add_instr(3, store_word(1, 0, 'h1F8));
    add_instr(3, branch_word(1, 1, 1, 8));
    add_instr(3, store_word(2, 0, 'h108));
    add_instr(3, branch_word(4, 1, 2, 8));            // blt taken
    add_instr(3, store_word(1, 0, 'h1F8));
    add_instr(3, branch_word(4, 2, 1, 8));
    add_instr(3, store_word(1, 0, 'h110));
    add_instr(3, branch_word(5, 2, 1, 8));            // bge taken
    add_instr(3, store_word(1, 0, 'h1F8));
    add_instr(3, branch_word(5, 1, 2, 8));
    add_instr(3, store_word(1, 0, 'h118));
    add_instr(3, branch_word(6, 2, 1, 8));            // bltu taken
    add_instr(3, store_word(1, 0, 'h1F8));
    add_instr(3, branch_word(6, 1, 2, 8));
    add_instr(3, store_word(2, 0, 'h120));
    add_instr(3, branch_word(7, 1, 2, 8));            // bgeu taken
    add_instr(3, store_word(1, 0, 'h1F8));
    add_instr(3, branch_word(7, 2, 1, 8));
    add_instr(3, store_word(2, 0, 'h128));
    add_instr(3, 32'h0010_0073);
    add_expected_store(3, 'h100, 64'h1);
    add_expected_store(3, 'h108, 64'h1);
    add_expected_store(3, 'h110, 64'hFFFF_FFFF_FFFF_FFFF);
    add_expected_store(3, 'h118, 64'hFFFF_FFFF_FFFF_FFFF);
    add_expected_store(3, 'h120, 64'h1);
    add_expected_store(3, 'h128, 64'h1);
    // program 4: jal and jalr with an odd target
    add_instr(4, jal_word(1, 12));                    // to 0x0c
    add_instr(4, store_word(0, 0, 'h1F8));
    add_instr(4, store_word(0, 0, 'h1F8));
    add_instr(4, store_word(1, 0, 'h100));
    add_instr(4, itype_word('h13, 0, 5, 0, 'h21));
    add_instr(4, itype_word('h67, 0, 6, 5, 0));       // jalr to 0x20
    add_instr(4, store_word(0, 0, 'h1F8));
    add_instr(4, store_word(0, 0, 'h1F8));
    add_instr(4, store_word(6, 0, 'h108));
    add_instr(4, 32'h0010_0073);
    add_expected_store(4, 'h100, 64'h4);
    add_expected_store(4, 'h108, 64'h18);
endtask

`endif

// File: verification/tb_cpu_core.sv
// testbench that runs each program of the table on cpu_core up to ebreak and checks its stores
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu_core;

    localparam int NUM_PROGRAMS = 5;
    localparam int MAX_INSTR    = 64;
    localparam int MAX_STORES   = 16;

    logic                 clk_1hz;
    logic                 reset_n;
    logic [`CPU_XLEN-1:0] i_mem_addr;
    logic [`CPU_ILEN-1:0] i_mem_data;
    logic [`CPU_XLEN-1:0] d_mem_addr;
    logic [`CPU_XLEN-1:0] d_mem_wdata;
    logic                 d_mem_we;
    logic [`CPU_XLEN-1:0] d_mem_rdata;
    logic                 halted;

    logic [`CPU_ILEN-1:0] imem [MAX_INSTR];    // 64 words covering 256 bytes
    logic [`CPU_XLEN-1:0] dmem [64];           // 64 doublewords covering 512 bytes

    // program table filled by build_program_table
    logic [`CPU_ILEN-1:0] prog_code [NUM_PROGRAMS][MAX_INSTR];
    int                   prog_len  [NUM_PROGRAMS];
    logic [`CPU_XLEN-1:0] data_init [NUM_PROGRAMS][4];  // words at 0x80..0x98
    logic [`CPU_XLEN-1:0] exp_addr  [NUM_PROGRAMS][MAX_STORES];
    logic [`CPU_XLEN-1:0] exp_data  [NUM_PROGRAMS][MAX_STORES];
    int                   exp_count [NUM_PROGRAMS];

    int cycle_count;
    int cycle_limit;

    cpu_core uut (
        .clk_1hz    (clk_1hz),
        .reset_n    (reset_n),
        .i_mem_addr (i_mem_addr),
        .i_mem_data (i_mem_data),
        .d_mem_addr (d_mem_addr),
        .d_mem_wdata(d_mem_wdata),
        .d_mem_we   (d_mem_we),
        .d_mem_rdata(d_mem_rdata),
        .halted     (halted)
    );

    always #5 clk_1hz = ~clk_1hz;              // 10 ns period

    // combinational memory reads with a nop outside the program area
    assign i_mem_data  = (i_mem_addr < 64'd256) ? imem[i_mem_addr[7:2]] : `CPU_NOP_WORD;
    assign d_mem_rdata = dmem[d_mem_addr[8:3]];

    always @(posedge clk_1hz) begin
        if (d_mem_we) begin
            dmem[d_mem_addr[8:3]] <= d_mem_wdata;
        end
    end

    // instruction encoders following the isa field layout
    function automatic logic [31:0] itype_word(int op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] rtype_word(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] store_word(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'h23};   // sd
    endfunction

    function automatic logic [31:0] branch_word(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] utype_word(int op, int rd, int imm);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] jal_word(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    `include "tb_program_table.svh"

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    // copy one program and its data into the memories and fill the rest
    task automatic load_program(input int p);
        for (int i = 0; i < MAX_INSTR; i++) begin
            imem[i] = (i < prog_len[p]) ? prog_code[p][i] : `CPU_NOP_WORD;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 64'(i) * 64'h0101_0101_0101_0101;
        end
        for (int i = 0; i < 4; i++) begin
            dmem[16 + i] = data_init[p][i];
        end
    endtask

    task automatic run_program(input int p);
        int store_idx;
        store_idx = 0;
        load_program(p);                               // core is halted or in reset here
        @(posedge clk_1hz);
        reset_n <= 1'b0;
        @(negedge clk_1hz);
        check_value("d_mem_we", d_mem_we, 0);          // idle outputs in reset
        check_value("halted", halted, 0);
        check_value("i_mem_addr", i_mem_addr, `CPU_RESET_PC);
        repeat (5) @(posedge clk_1hz);
        reset_n <= 1'b1;
        do begin
            @(negedge clk_1hz);                        // outputs settled mid cycle
            if (d_mem_we) begin
                if (store_idx >= exp_count[p]) begin
                    report_failure($sformatf("program %0d made an extra store to %h",
                                             p, d_mem_addr));
                end else begin
                    check_value("d_mem_addr", d_mem_addr, exp_addr[p][store_idx]);
                    check_value("d_mem_wdata", d_mem_wdata, exp_data[p][store_idx]);
                    store_idx++;
                end
            end
        end while (!halted);
        if (store_idx != exp_count[p]) begin
            report_failure($sformatf("program %0d halted after %0d of %0d stores",
                                     p, store_idx, exp_count[p]));
        end
        repeat (2) begin
            @(negedge clk_1hz);
            check_value("d_mem_we", d_mem_we, 0);      // nothing after ebreak
            check_value("halted", halted, 1);
        end
    endtask

    // timeout watchdog
    always @(posedge clk_1hz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            report_failure($sformatf("timeout, core did not halt within %0d cycles",
                                     cycle_limit));
        end
    end

    initial begin
        int total_instr;
        clk_1hz     = 1'b0;
        reset_n     = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        total_instr = 0;
        build_program_table();
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            total_instr += prog_len[p];
        end
        cycle_limit = 4 * total_instr + 50 * NUM_PROGRAMS;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            run_program(p);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: rtl/cpu_core.sv
// top of the two-stage rv64 core, connects fetch and execute to the memory ports
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core (
    input  logic                 clk_1hz,
    input  logic                 reset_n,
    output logic [`CPU_XLEN-1:0] i_mem_addr,
    input  logic [`CPU_ILEN-1:0] i_mem_data,    // returned in the same cycle
    output logic [`CPU_XLEN-1:0] d_mem_addr,
    output logic [`CPU_XLEN-1:0] d_mem_wdata,
    output logic                 d_mem_we,
    input  logic [`CPU_XLEN-1:0] d_mem_rdata,   // asynchronous read
    output logic                 halted
);

    logic [`CPU_XLEN-1:0]  pc, target, instr_pc, imm;
    logic [`CPU_XLEN-1:0]  rs1_data, rs2_data, alu_a, alu_b, alu_result, wb_data;
    logic [`CPU_ILEN-1:0]  instr;
    logic                  redirect, exec_valid, flush, halt_req, branch_taken;
    logic                  alu_src_imm, reg_write, mem_write;
    logic                  is_branch, is_jal, is_jalr, is_ebreak, is_auipc;
    logic [2:0]            branch_cond;
    rv_isa_pkg::reg_idx_t  rs1, rs2, rd;
    cpu_ctrl_pkg::alu_op_t alu_op;
    cpu_ctrl_pkg::wb_sel_t wb_sel;

    program_counter u_pc (
        .clk_1hz (clk_1hz),
        .reset_n (reset_n),
        .redirect(redirect),
        .target  (target),
        .hold    (halted),
        .pc      (pc)
    );

    pipeline_control u_ctrl (
        .clk_1hz   (clk_1hz),
        .reset_n   (reset_n),
        .redirect  (redirect),
        .halt_req  (halt_req),
        .exec_valid(exec_valid),
        .flush     (flush),
        .halted    (halted)
    );

    fetch_stage u_fetch (
        .clk_1hz (clk_1hz),
        .reset_n (reset_n),
        .pc      (pc),
        .instr_in(i_mem_data),
        .flush   (flush),
        .halted  (halted),
        .instr   (instr),
        .instr_pc(instr_pc)
    );

    instr_decoder u_dec (
        .instr      (instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .alu_op     (alu_op),
        .alu_src_imm(alu_src_imm),
        .reg_write  (reg_write),
        .mem_write  (mem_write),
        .is_branch  (is_branch),
        .is_jal     (is_jal),
        .is_jalr    (is_jalr),
        .is_ebreak  (is_ebreak),
        .wb_sel     (wb_sel),
        .branch_cond(branch_cond)
    );

    register_file u_rf (
        .clk_1hz   (clk_1hz),
        .reset_n   (reset_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .write_en  (reg_write && exec_valid),   // flushed or fill slots write nothing
        .write_data(wb_data),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    // auipc adds to the instruction address instead of rs1
    assign is_auipc = (instr[6:0] == rv_isa_pkg::OP_AUIPC);
    assign alu_a    = is_auipc ? instr_pc : rs1_data;
    assign alu_b    = alu_src_imm ? imm : rs2_data;

    alu u_alu (
        .op          (alu_op),
        .a           (alu_a),
        .b           (alu_b),
        .branch_cond (branch_cond),
        .result      (alu_result),
        .branch_taken(branch_taken)
    );

    // jalr drops bit 0, branch and jal are pc relative
    assign target   = is_jalr ? {alu_result[`CPU_XLEN-1:1], 1'b0} : instr_pc + imm;
    assign redirect = exec_valid && (is_jal || is_jalr || (is_branch && branch_taken));
    assign halt_req = exec_valid && is_ebreak;

    always_comb begin
        case (wb_sel)
            cpu_ctrl_pkg::WB_LOAD: wb_data = d_mem_rdata;
            cpu_ctrl_pkg::WB_LINK: wb_data = instr_pc + `CPU_XLEN'd4;   // return address
            default:               wb_data = alu_result;
        endcase
    end

    assign i_mem_addr  = pc;
    assign d_mem_addr  = alu_result;             // rs1 + offset for ld and sd
    assign d_mem_wdata = rs2_data;
    assign d_mem_we    = mem_write && exec_valid;

endmodule

// File: rtl/alu.sv
// integer alu with shifts and compares, plus the branch condition check on the same operands
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu (
    input  cpu_ctrl_pkg::alu_op_t op,
    input  logic [`CPU_XLEN-1:0]  a,
    input  logic [`CPU_XLEN-1:0]  b,
    input  logic [2:0]            branch_cond,   // funct3 of the branch
    output logic [`CPU_XLEN-1:0]  result,
    output logic                  branch_taken
);

    logic [5:0] shamt;
    logic       eq, lt_s, lt_u;

    assign shamt = b[5:0];                          // rv64 shifts use six bits
    assign eq    = (a == b);
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    always_comb begin
        case (op)
            cpu_ctrl_pkg::ALU_ADD:    result = a + b;
            cpu_ctrl_pkg::ALU_SUB:    result = a - b;
            cpu_ctrl_pkg::ALU_SLL:    result = a << shamt;
            cpu_ctrl_pkg::ALU_SLT:    result = {{(`CPU_XLEN-1){1'b0}}, lt_s};
            cpu_ctrl_pkg::ALU_SLTU:   result = {{(`CPU_XLEN-1){1'b0}}, lt_u};
            cpu_ctrl_pkg::ALU_XOR:    result = a ^ b;
            cpu_ctrl_pkg::ALU_SRL:    result = a >> shamt;
            cpu_ctrl_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            cpu_ctrl_pkg::ALU_OR:     result = a | b;
            cpu_ctrl_pkg::ALU_AND:    result = a & b;
            cpu_ctrl_pkg::ALU_PASS_B: result = b;
            default:                  result = '0;
        endcase
    end

    always_comb begin
        case (branch_cond)
            rv_isa_pkg::F3_BEQ:  branch_taken = eq;
            rv_isa_pkg::F3_BNE:  branch_taken = !eq;
            rv_isa_pkg::F3_BLT:  branch_taken = lt_s;
            rv_isa_pkg::F3_BGE:  branch_taken = !lt_s;
            rv_isa_pkg::F3_BLTU: branch_taken = lt_u;
            rv_isa_pkg::F3_BGEU: branch_taken = !lt_u;
            default:             branch_taken = 1'b0;   // reserved codes never branch
        endcase
    end

endmodule

// File: rtl/register_file.sv
// general register file, two async reads, one clocked write, x0 stays zero
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register_file (
    input  logic                 clk_1hz,
    input  logic                 reset_n,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    input  rv_isa_pkg::reg_idx_t rd,
    input  logic                 write_en,
    input  logic [`CPU_XLEN-1:0] write_data,
    output logic [`CPU_XLEN-1:0] rs1_data,
    output logic [`CPU_XLEN-1:0] rs2_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (rd != '0)) begin   // x0 never written
            regs[rd] <= write_data;
        end
    end

    // combinational read, new value visible the cycle after a write
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// File: rtl/instr_decoder.sv
// splits an instruction into fields and immediates and builds the execute control set
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instr_decoder (
    input  logic [`CPU_ILEN-1:0]   instr,
    output rv_isa_pkg::reg_idx_t   rs1,
    output rv_isa_pkg::reg_idx_t   rs2,
    output rv_isa_pkg::reg_idx_t   rd,
    output logic [`CPU_XLEN-1:0]   imm,
    output cpu_ctrl_pkg::alu_op_t  alu_op,
    output logic                   alu_src_imm,
    output logic                   reg_write,
    output logic                   mem_write,
    output logic                   is_branch,
    output logic                   is_jal,
    output logic                   is_jalr,
    output logic                   is_ebreak,
    output cpu_ctrl_pkg::wb_sel_t  wb_sel,
    output logic [2:0]             branch_cond
);

    rv_isa_pkg::opcode_t opcode;
    logic [2:0]          funct3;
    logic                alt;        // sub / sra select
    logic [`CPU_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode      = rv_isa_pkg::opcode_t'(instr[6:0]);
    assign funct3      = instr[14:12];
    assign alt         = instr[25 + rv_isa_pkg::F7_ALT_BIT];
    assign rs1         = instr[19:15];
    assign rs2         = instr[24:20];
    assign rd          = instr[11:7];
    assign branch_cond = funct3;

    // sign-extended immediates, all formats
    assign imm_i = {{(`CPU_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`CPU_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`CPU_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {{(`CPU_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{(`CPU_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // funct3 group to alu operation, shared by op and op_imm
    function automatic cpu_ctrl_pkg::alu_op_t alu_from_f3(input logic [2:0] f3,
                                                          input logic use_alt);
        cpu_ctrl_pkg::alu_op_t op;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: op = use_alt ? cpu_ctrl_pkg::ALU_SUB : cpu_ctrl_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     op = cpu_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     op = cpu_ctrl_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    op = cpu_ctrl_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     op = cpu_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: op = use_alt ? cpu_ctrl_pkg::ALU_SRA : cpu_ctrl_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      op = cpu_ctrl_pkg::ALU_OR;
            default:                op = cpu_ctrl_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // defaults give a no-operation
        imm         = imm_i;
        alu_op      = cpu_ctrl_pkg::ALU_ADD;
        alu_src_imm = 1'b1;
        reg_write   = 1'b0;
        mem_write   = 1'b0;
        is_branch   = 1'b0;
        is_jal      = 1'b0;
        is_jalr     = 1'b0;
        is_ebreak   = 1'b0;
        wb_sel      = cpu_ctrl_pkg::WB_ALU;
        case (opcode)
            rv_isa_pkg::OP_LUI: begin
                imm       = imm_u;
                alu_op    = cpu_ctrl_pkg::ALU_PASS_B;
                reg_write = 1'b1;
            end
            rv_isa_pkg::OP_AUIPC: begin
                imm       = imm_u;                       // a side is the pc, see core
                reg_write = 1'b1;
            end
            rv_isa_pkg::OP_JAL: begin
                imm       = imm_j;
                is_jal    = 1'b1;
                reg_write = 1'b1;
                wb_sel    = cpu_ctrl_pkg::WB_LINK;
            end
            rv_isa_pkg::OP_JALR: begin
                is_jalr   = 1'b1;                        // target from rs1 + imm_i
                reg_write = 1'b1;
                wb_sel    = cpu_ctrl_pkg::WB_LINK;
            end
            rv_isa_pkg::OP_BRANCH: begin
                imm         = imm_b;
                alu_src_imm = 1'b0;                      // compare rs1 with rs2
                is_branch   = 1'b1;
            end
            rv_isa_pkg::OP_LOAD: begin
                reg_write = (funct3 == rv_isa_pkg::F3_DOUBLE);   // ld only
                wb_sel    = cpu_ctrl_pkg::WB_LOAD;
            end
            rv_isa_pkg::OP_STORE: begin
                imm       = imm_s;
                mem_write = (funct3 == rv_isa_pkg::F3_DOUBLE);   // sd only
            end
            rv_isa_pkg::OP_IMM: begin
                // shamt sits in imm[5:0], bit 10 marks srai
                alu_op    = alu_from_f3(funct3, alt && (funct3 == rv_isa_pkg::F3_SRL_SRA));
                reg_write = 1'b1;
            end
            rv_isa_pkg::OP_REG: begin
                alu_op      = alu_from_f3(funct3, alt);
                alu_src_imm = 1'b0;
                reg_write   = 1'b1;
            end
            rv_isa_pkg::OP_SYSTEM: begin
                is_ebreak = (funct3 == rv_isa_pkg::F3_PRIV) &&
                            (instr[31:20] == rv_isa_pkg::F12_EBREAK);
            end
            default: ;                                   // unknown opcode, nothing written
        endcase
    end

endmodule

// File: rtl/fetch_stage.sv
// pipeline register carrying the fetched word and its address into execute
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_stage (
    input  logic                 clk_1hz,
    input  logic                 reset_n,
    input  logic [`CPU_XLEN-1:0] pc,
    input  logic [`CPU_ILEN-1:0] instr_in,   // same-cycle instruction memory data
    input  logic                 flush,
    input  logic                 halted,
    output logic [`CPU_ILEN-1:0] instr,
    output logic [`CPU_XLEN-1:0] instr_pc
);

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            instr    <= `CPU_NOP_WORD;
            instr_pc <= `CPU_RESET_PC;
        end else if (flush) begin
            instr    <= `CPU_NOP_WORD;       // drop the wrong-path word
            instr_pc <= pc;
        end else if (!halted) begin
            instr    <= instr_in;
            instr_pc <= pc;
        end
    end

endmodule

// File: rtl/pipeline_control.sv
// fsm sequencing fill, run, flush and halt, and marking the execute slot valid
`timescale 1ns/1ps

module pipeline_control (
    input  logic clk_1hz,
    input  logic reset_n,
    input  logic redirect,
    input  logic halt_req,     // ebreak in a valid slot
    output logic exec_valid,
    output logic flush,
    output logic halted
);

    cpu_ctrl_pkg::pipe_state_t state;
    cpu_ctrl_pkg::pipe_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            cpu_ctrl_pkg::PS_FILL:  state_next = cpu_ctrl_pkg::PS_RUN;
            cpu_ctrl_pkg::PS_RUN: begin
                if (halt_req) begin
                    state_next = cpu_ctrl_pkg::PS_HALTED;
                end else if (redirect) begin
                    state_next = cpu_ctrl_pkg::PS_FLUSH;   // one idle slot
                end
            end
            cpu_ctrl_pkg::PS_FLUSH:  state_next = cpu_ctrl_pkg::PS_RUN;
            cpu_ctrl_pkg::PS_HALTED: state_next = cpu_ctrl_pkg::PS_HALTED;
            default:                 state_next = cpu_ctrl_pkg::PS_FILL;
        endcase
    end

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            state <= cpu_ctrl_pkg::PS_FILL;
        end else begin
            state <= state_next;
        end
    end

    assign exec_valid = (state == cpu_ctrl_pkg::PS_RUN);
    // the wrong-path word is being fetched in the redirect cycle itself
    assign flush      = exec_valid && redirect;
    assign halted     = (state == cpu_ctrl_pkg::PS_HALTED);

endmodule

// File: rtl/program_counter.sv
// fetch address register, steps by four, takes redirect targets and freezes when held
`timescale 1ns/1ps
`include "cpu_settings.svh"

module program_counter (
    input  logic                 clk_1hz,
    input  logic                 reset_n,
    input  logic                 redirect,   // taken branch or jump in execute
    input  logic [`CPU_XLEN-1:0] target,
    input  logic                 hold,       // core halted
    output logic [`CPU_XLEN-1:0] pc
);

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            pc <= `CPU_RESET_PC;
        end else if (redirect) begin
            pc <= target;                    // new fetch address next cycle
        end else if (!hold) begin
            pc <= pc + `CPU_XLEN'd4;
        end
    end

endmodule

// File: rtl/cpu_ctrl_pkg.sv
// internal control types passed between decoder, alu and pipeline sequencing
package cpu_ctrl_pkg;

    // operations the alu can perform
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B        // lui, b carries the upper immediate
    } alu_op_t;

    // where the register write data comes from
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK           // instruction address plus four
    } wb_sel_t;

    typedef enum logic [1:0] {
        PS_FILL,          // first cycle after reset, fetch register holds a nop
        PS_RUN,
        PS_FLUSH,         // wrong-path slot after a redirect
        PS_HALTED
    } pipe_state_t;

endpackage

// File: rtl/rv_isa_pkg.sv
// instruction set encodings for the kept rv64i subset, referenced by scoped name
package rv_isa_pkg;

    // major opcodes that the decoder understands
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    typedef logic [4:0] reg_idx_t;                 // x0..x31

    // alu groups, shared by op and op_imm
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_DOUBLE = 3'b011;     // ld / sd size
    localparam logic [2:0] F3_PRIV   = 3'b000;     // ecall / ebreak group

    localparam int unsigned F7_ALT_BIT = 5;        // funct7 bit for sub and sra
    localparam logic [11:0] F12_EBREAK = 12'h001;

endpackage

// File: rtl/cpu_settings.svh
// core-wide width and reset constants, included by every rtl and testbench file that needs them
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// register and data path width
`define CPU_XLEN 64

`define CPU_ILEN 32                        // instruction word width
`define CPU_NREGS 32                       // x0..x31

// first fetch address after reset
`define CPU_RESET_PC 64'h0000_0000_0000_0000

`define CPU_NOP_WORD 32'h0000_0013         // addi x0, x0, 0

`endif
